/* logic/pm_pkg.sv */
`default_nettype none

package pm_pkg;

    // --------------------
    // Micro-operations
    // --------------------
    typedef enum logic [2:0] {
        UOP_NOP       = 3'd0,  // Bubble, nothing issued
        UOP_LOAD_ZERO = 3'd1,  // Rc = 0
        UOP_LOAD_ONE  = 3'd2,  // Rc = 1
        UOP_LOAD_X    = 3'd3,  // Rc = operand_i
        UOP_ADD       = 3'd4,  // Rc = Ra + Rb mod p
        UOP_MUL       = 3'd5,  // Rc = Ra * Rb mod p, multi-cycle
        UOP_OUT       = 3'd6   // result_o = Ra
    } pm_opcode_e;

    // Host commands
    typedef enum logic [1:0] {
        CMD_NONE   = 2'd0,
        CMD_SCALE  = 2'd1,  // k*x, additive ladder
        CMD_POWER  = 2'd2,  // x^k, multiplicative ladder
        CMD_INVERT = 2'd3   // x^(p-2), Fermat inverse
    } pm_cmd_e;

    // --------------------
    // Register file
    // --------------------
    localparam int REG_ADDR_W = 3;  // Eight working registers

    localparam logic [REG_ADDR_W-1:0] REG_R0 = 3'd0;  // Ladder register R0
    localparam logic [REG_ADDR_W-1:0] REG_R1 = 3'd1;  // Ladder register R1

    // Issued instruction word, 12 bits
    typedef struct packed {
        pm_opcode_e              opcode;
        logic [REG_ADDR_W-1:0]   opa_addr;  // First source
        logic [REG_ADDR_W-1:0]   opb_addr;  // Second source
        logic [REG_ADDR_W-1:0]   opc_addr;  // Destination
    } pm_instr_t;

    localparam pm_instr_t NOP_INSTR = '{UOP_NOP, '0, '0, '0};

    // --------------------
    // Microcode map
    // --------------------
    localparam int PROG_ADDR_W = 5;

    // Every routine ends on a NOP word the sequencer recognizes
    localparam logic [PROG_ADDR_W-1:0] IDLE       = 5'd0;
    localparam logic [PROG_ADDR_W-1:0] ADD_INIT_S = 5'd1;   // R0 = 0, R1 = x
    localparam logic [PROG_ADDR_W-1:0] ADD_INIT_E = 5'd3;
    localparam logic [PROG_ADDR_W-1:0] MUL_INIT_S = 5'd4;   // R0 = 1, R1 = x
    localparam logic [PROG_ADDR_W-1:0] MUL_INIT_E = 5'd6;
    localparam logic [PROG_ADDR_W-1:0] ADD_STEP_S = 5'd7;   // Additive ladder step
    localparam logic [PROG_ADDR_W-1:0] ADD_STEP_E = 5'd9;
    localparam logic [PROG_ADDR_W-1:0] MUL_STEP_S = 5'd10;  // Multiplicative ladder step
    localparam logic [PROG_ADDR_W-1:0] MUL_STEP_E = 5'd12;
    localparam logic [PROG_ADDR_W-1:0] OUT_S      = 5'd13;  // Emit R0
    localparam logic [PROG_ADDR_W-1:0] OUT_E      = 5'd14;

endpackage

`default_nettype wire

/* logic/pm_instr_if.sv */
`default_nettype none

// Issued micro-instruction, controller to arithmetic unit
interface pm_instr_if (
    input logic clk
);

    pm_pkg::pm_opcode_e                opcode;    // UOP_NOP means no issue
    logic [pm_pkg::REG_ADDR_W-1:0]     opa_addr;
    logic [pm_pkg::REG_ADDR_W-1:0]     opb_addr;
    logic [pm_pkg::REG_ADDR_W-1:0]     opc_addr;  // Destination

    // Sequencer side
    modport ctrl  (input clk, output opcode, output opa_addr, output opb_addr, output opc_addr);

    // Datapath side
    modport arith (input clk, input opcode, input opa_addr, input opb_addr, input opc_addr);

endinterface

`default_nettype wire

/* logic/pm_program_rom.sv */
`default_nettype none

module pm_program_rom (
    input  logic [pm_pkg::PROG_ADDR_W-1:0] addr_i,
    output pm_pkg::pm_instr_t              instr_o
);

    // Short aliases for the ladder registers
    localparam logic [pm_pkg::REG_ADDR_W-1:0] R0 = pm_pkg::REG_R0;
    localparam logic [pm_pkg::REG_ADDR_W-1:0] R1 = pm_pkg::REG_R1;

    localparam logic [pm_pkg::PROG_ADDR_W-1:0] ONE = 5'd1;

    always_comb begin : rom_lookup
        instr_o = pm_pkg::NOP_INSTR;  // Unused words read as NOP
        case (addr_i)
            // --------------------
            // Ladder init
            // --------------------
            pm_pkg::ADD_INIT_S: begin
                instr_o = '{pm_pkg::UOP_LOAD_ZERO, R0, R0, R0};  // R0 = 0
            end
            pm_pkg::ADD_INIT_S + ONE: begin
                instr_o = '{pm_pkg::UOP_LOAD_X, R0, R0, R1};     // R1 = x
            end
            pm_pkg::MUL_INIT_S: begin
                instr_o = '{pm_pkg::UOP_LOAD_ONE, R0, R0, R0};   // R0 = 1
            end
            pm_pkg::MUL_INIT_S + ONE: begin
                instr_o = '{pm_pkg::UOP_LOAD_X, R0, R0, R1};     // R1 = x
            end

            // --------------------
            // Ladder steps
            // --------------------
            // R0/R1 addresses get bit 0 flipped by the current digit downstream
            pm_pkg::ADD_STEP_S: begin
                instr_o = '{pm_pkg::UOP_ADD, R0, R1, R1};        // R(1^d) = R0 + R1
            end
            pm_pkg::ADD_STEP_S + ONE: begin
                instr_o = '{pm_pkg::UOP_ADD, R0, R0, R0};        // R(d) = 2 R(d)
            end
            pm_pkg::MUL_STEP_S: begin
                instr_o = '{pm_pkg::UOP_MUL, R0, R1, R1};        // R(1^d) = R0 * R1
            end
            pm_pkg::MUL_STEP_S + ONE: begin
                instr_o = '{pm_pkg::UOP_MUL, R0, R0, R0};        // R(d) = R(d)^2
            end

            // Result
            pm_pkg::OUT_S: begin
                instr_o = '{pm_pkg::UOP_OUT, R0, R0, R0};        // result_o = R0
            end

            // Routine ends, decoded by the sequencer
            pm_pkg::IDLE,
            pm_pkg::ADD_INIT_E,
            pm_pkg::MUL_INIT_E,
            pm_pkg::ADD_STEP_E,
            pm_pkg::MUL_STEP_E,
            pm_pkg::OUT_E: begin
                instr_o = pm_pkg::NOP_INSTR;
            end

            default: begin
                instr_o = pm_pkg::NOP_INSTR;
            end
        endcase
    end

endmodule

`default_nettype wire

/* logic/pm_ctrl.sv */
`default_nettype none

module pm_ctrl #(
    parameter int WIDTH = 16,
    parameter int PRIME = 65521
) (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize_i,
    input  pm_pkg::pm_cmd_e                cmd_i,
    input  logic [WIDTH-1:0]               scalar_i,
    input  pm_pkg::pm_instr_t              prog_instr_i,   // ROM word, same cycle
    output logic [pm_pkg::PROG_ADDR_W-1:0] prog_addr_o,
    output logic                           busy_o,
    pm_instr_if.ctrl                       instr
);

    // --------------------
    // Constants
    // --------------------
    localparam int CNT_W   = $clog2(WIDTH + 1);
    localparam int STALL_W = $clog2(WIDTH + 2);

    localparam logic [STALL_W-1:0] ADD_DELAY = STALL_W'(1);          // One bubble after ADD
    localparam logic [STALL_W-1:0] MUL_DELAY = STALL_W'(WIDTH + 1);  // Covers serial multiply
    localparam logic [WIDTH-1:0]   INV_EXP   = WIDTH'(PRIME - 2);    // Fermat exponent

    // --------------------
    // State
    // --------------------
    logic [pm_pkg::PROG_ADDR_W-1:0] prog_cntr;
    logic [CNT_W-1:0]               ladder_cnt;   // Steps left
    logic [STALL_W-1:0]             stall_cnt;
    logic                           ladder_on;    // Swap window
    pm_pkg::pm_cmd_e                cmd_q;
    logic [WIDTH-1:0]               scalar_q;     // MSB is the current digit

    pm_pkg::pm_instr_t pipe1, pipe2, issue_q;
    logic              digit_p1, digit_p2;       // Digit that travels with each word

    logic                           stalled;
    logic                           digit;
    logic [pm_pkg::PROG_ADDR_W-1:0] step_start;

    assign stalled    = (stall_cnt != '0);
    assign digit      = ladder_on & scalar_q[WIDTH-1];
    assign step_start = (cmd_q == pm_pkg::CMD_SCALE) ? pm_pkg::ADD_STEP_S : pm_pkg::MUL_STEP_S;

    assign prog_addr_o = prog_cntr;
    assign busy_o      = (prog_cntr != pm_pkg::IDLE);

    // Flip bit 0 of a ladder register address
    function automatic logic [pm_pkg::REG_ADDR_W-1:0] swap_addr(
        input logic [pm_pkg::REG_ADDR_W-1:0] addr,
        input logic                          d
    );
        if (addr < pm_pkg::REG_ADDR_W'(2)) begin
            return {addr[pm_pkg::REG_ADDR_W-1:1], addr[0] ^ d};
        end
        return addr;
    endfunction

    // --------------------
    // Program sequencer
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin : seq_fsm
        if (!reset_n) begin
            prog_cntr  <= pm_pkg::IDLE;
            ladder_cnt <= '0;
            ladder_on  <= 1'b0;
            cmd_q      <= pm_pkg::CMD_NONE;
            scalar_q   <= '0;
        end else if (zeroize_i) begin
            prog_cntr  <= pm_pkg::IDLE;
            ladder_cnt <= '0;
            ladder_on  <= 1'b0;
            cmd_q      <= pm_pkg::CMD_NONE;
            scalar_q   <= '0;
        end else if (!stalled) begin
            case (prog_cntr)
                pm_pkg::IDLE: begin
                    if (cmd_i != pm_pkg::CMD_NONE) begin
                        cmd_q      <= cmd_i;
                        scalar_q   <= (cmd_i == pm_pkg::CMD_INVERT) ? INV_EXP : scalar_i;
                        ladder_cnt <= CNT_W'(WIDTH);
                        prog_cntr  <= (cmd_i == pm_pkg::CMD_SCALE) ? pm_pkg::ADD_INIT_S
                                                                   : pm_pkg::MUL_INIT_S;
                    end
                end
                pm_pkg::ADD_INIT_E,
                pm_pkg::MUL_INIT_E: begin
                    ladder_on  <= 1'b1;                // MSB already exposed
                    ladder_cnt <= ladder_cnt - 1'b1;
                    prog_cntr  <= step_start;
                end
                pm_pkg::ADD_STEP_E,
                pm_pkg::MUL_STEP_E: begin
                    if (ladder_cnt == '0) begin
                        ladder_on <= 1'b0;             // Ladder done
                        prog_cntr <= pm_pkg::OUT_S;
                    end else begin
                        ladder_cnt <= ladder_cnt - 1'b1;
                        scalar_q   <= scalar_q << 1;   // Next digit
                        prog_cntr  <= step_start;
                    end
                end
                pm_pkg::OUT_E: prog_cntr <= pm_pkg::IDLE;
                default:       prog_cntr <= prog_cntr + 1'b1;
            endcase
        end
    end

    // --------------------
    // Pipeline and issue
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin : instr_pipe
        if (!reset_n) begin
            pipe1     <= pm_pkg::NOP_INSTR;
            pipe2     <= pm_pkg::NOP_INSTR;
            issue_q   <= pm_pkg::NOP_INSTR;
            digit_p1  <= 1'b0;
            digit_p2  <= 1'b0;
            stall_cnt <= '0;
        end else if (zeroize_i) begin
            pipe1     <= pm_pkg::NOP_INSTR;
            pipe2     <= pm_pkg::NOP_INSTR;
            issue_q   <= pm_pkg::NOP_INSTR;
            digit_p1  <= 1'b0;
            digit_p2  <= 1'b0;
            stall_cnt <= '0;
        end else if (stalled) begin
            issue_q   <= pm_pkg::NOP_INSTR;   // Bubbles while frozen
            stall_cnt <= stall_cnt - 1'b1;
        end else begin
            pipe1    <= prog_instr_i;
            digit_p1 <= digit;
            pipe2    <= pipe1;
            digit_p2 <= digit_p1;
            // Constant-time swap of R0/R1 by the carried digit
            issue_q.opcode   <= pipe2.opcode;
            issue_q.opa_addr <= swap_addr(pipe2.opa_addr, digit_p2);
            issue_q.opb_addr <= swap_addr(pipe2.opb_addr, digit_p2);
            issue_q.opc_addr <= swap_addr(pipe2.opc_addr, digit_p2);
            case (pipe2.opcode)
                pm_pkg::UOP_ADD: stall_cnt <= ADD_DELAY;
                pm_pkg::UOP_MUL: stall_cnt <= MUL_DELAY;
                default:         stall_cnt <= '0;
            endcase
        end
    end

    assign instr.opcode   = issue_q.opcode;
    assign instr.opa_addr = issue_q.opa_addr;
    assign instr.opb_addr = issue_q.opb_addr;
    assign instr.opc_addr = issue_q.opc_addr;

    // --------------------
    // Checks
    // --------------------
    a_zeroize_idle : assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> !busy_o);

    // Counter holds at zero until the sequencer is back in IDLE
    a_ladder_no_underflow : assert property (@(posedge clk) disable iff (!reset_n)
        (ladder_cnt == '0) && (prog_cntr != pm_pkg::IDLE) |=> (ladder_cnt == '0));

endmodule

`default_nettype wire

/* logic/pm_arith_unit.sv */
`default_nettype none

module pm_arith_unit #(
    parameter int WIDTH = 16,
    parameter int PRIME = 65521
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize_i,
    input  logic [WIDTH-1:0] operand_i,       // Stable while busy
    output logic [WIDTH-1:0] result_o,
    output logic             result_valid_o,  // One-cycle pulse
    pm_instr_if.arith        instr
);

    localparam int             MUL_CNT_W = $clog2(WIDTH + 2);
    localparam logic [WIDTH:0] P_EXT     = (WIDTH + 1)'(PRIME);

    logic [WIDTH-1:0]              regs [8];   // R0, R1 are the ladder pair
    logic [MUL_CNT_W-1:0]          mul_cnt;    // Nonzero while multiplying
    logic [WIDTH-1:0]              mul_a;      // Multiplier, shifted out MSB first
    logic [WIDTH-1:0]              mul_b;
    logic [WIDTH-1:0]              mul_acc;
    logic [pm_pkg::REG_ADDR_W-1:0] mul_dst;

    // a + b mod p, both inputs already reduced
    function automatic logic [WIDTH-1:0] mod_add(
        input logic [WIDTH-1:0] a,
        input logic [WIDTH-1:0] b
    );
        logic [WIDTH:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= P_EXT) begin
            sum = sum - P_EXT;
        end
        return sum[WIDTH-1:0];
    endfunction

    // --------------------
    // Register file
    // --------------------
    always_ff @(posedge clk) begin : reg_file
        if (zeroize_i) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (instr.opcode)
                pm_pkg::UOP_LOAD_ZERO: regs[instr.opc_addr] <= '0;
                pm_pkg::UOP_LOAD_ONE:  regs[instr.opc_addr] <= WIDTH'(1);
                pm_pkg::UOP_LOAD_X:    regs[instr.opc_addr] <= operand_i;
                pm_pkg::UOP_ADD: begin
                    regs[instr.opc_addr] <= mod_add(regs[instr.opa_addr], regs[instr.opb_addr]);
                end
                default: ;
            endcase
            if (mul_cnt == MUL_CNT_W'(1)) begin
                regs[mul_dst] <= mul_acc;   // Product lands WIDTH+1 cycles after issue
            end
        end
    end

    // --------------------
    // Serial multiplier
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin : mul_ctrl
        if (!reset_n) begin
            mul_cnt <= '0;
        end else if (zeroize_i) begin
            mul_cnt <= '0;
        end else if (instr.opcode == pm_pkg::UOP_MUL) begin
            mul_cnt <= MUL_CNT_W'(WIDTH + 1);  // WIDTH iterations plus write-back
        end else if (mul_cnt != '0) begin
            mul_cnt <= mul_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin : mul_datapath
        if (zeroize_i) begin
            mul_a   <= '0;
            mul_b   <= '0;
            mul_acc <= '0;
            mul_dst <= '0;
        end else if (instr.opcode == pm_pkg::UOP_MUL) begin
            mul_a   <= regs[instr.opa_addr];   // Operands sampled at issue
            mul_b   <= regs[instr.opb_addr];
            mul_acc <= '0;
            mul_dst <= instr.opc_addr;
        end else if (mul_cnt > MUL_CNT_W'(1)) begin
            // Double, then add b when the multiplier bit is set
            mul_acc <= mod_add(mod_add(mul_acc, mul_acc), mul_a[WIDTH-1] ? mul_b : '0);
            mul_a   <= mul_a << 1;
        end
    end

    // --------------------
    // Result capture
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin : result_reg
        if (!reset_n) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            result_o       <= '0;
            result_valid_o <= 1'b0;   // Aborted run gives no pulse
        end else begin
            result_valid_o <= (instr.opcode == pm_pkg::UOP_OUT);
            if (instr.opcode == pm_pkg::UOP_OUT) begin
                result_o <= regs[instr.opa_addr];
            end
        end
    end

    // Sequencer stall must cover the whole multiply
    a_no_issue_during_mul : assert property (@(posedge instr.clk) disable iff (!reset_n)
        (mul_cnt != '0) |-> (instr.opcode == pm_pkg::UOP_NOP));

endmodule

`default_nettype wire

/* logic/pm_top.sv */
`default_nettype none

module pm_top #(
    parameter int WIDTH = 16,
    parameter int PRIME = 65521   // Any prime below 2^WIDTH
) (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             zeroize_i,
    input  pm_pkg::pm_cmd_e  cmd_i,      // Sampled while idle
    input  logic [WIDTH-1:0] operand_i,
    input  logic [WIDTH-1:0] scalar_i,
    output logic             busy_o,
    output logic [WIDTH-1:0] result_o,
    output logic             result_valid_o
);

    logic [pm_pkg::PROG_ADDR_W-1:0] prog_addr;
    pm_pkg::pm_instr_t              prog_instr;

    // Issue bus, controller to datapath
    pm_instr_if instr_bus (.clk(clk));

    // --------------------
    // Sequencer and microcode
    // --------------------
    pm_ctrl #(
        .WIDTH (WIDTH),
        .PRIME (PRIME)
    ) u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .cmd_i        (cmd_i),
        .scalar_i     (scalar_i),
        .prog_instr_i (prog_instr),
        .prog_addr_o  (prog_addr),
        .busy_o       (busy_o),
        .instr        (instr_bus.ctrl)
    );

    pm_program_rom u_rom (
        .addr_i  (prog_addr),
        .instr_o (prog_instr)   // Combinational lookup
    );

    // Modular datapath
    pm_arith_unit #(
        .WIDTH (WIDTH),
        .PRIME (PRIME)
    ) u_arith (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize_i),
        .operand_i      (operand_i),
        .result_o       (result_o),
        .result_valid_o (result_valid_o),
        .instr          (instr_bus.arith)
    );

endmodule

`default_nettype wire

/* tests/pm_tb.sv */
`default_nettype none

module pm_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    WIDTH      = 16;
    localparam int    PRIME      = 65521;
    localparam int    RUN_CYCLES = 2 * WIDTH * (WIDTH + 4);  // Budget for one command
    localparam string TEST_FILE  = "tests/pm_tests.txt";

    // DUT connections
    logic             clk;
    logic             reset_n;
    logic             zeroize_i;
    pm_pkg::pm_cmd_e  cmd_i;
    logic [WIDTH-1:0] operand_i;
    logic [WIDTH-1:0] scalar_i;
    logic             busy_o;
    logic [WIDTH-1:0] result_o;
    logic             result_valid_o;

    // Vectors from the data file
    pm_pkg::pm_cmd_e  vec_cmd [$];
    logic [WIDTH-1:0] vec_x [$];
    logic [WIDTH-1:0] vec_k [$];
    logic [WIDTH-1:0] vec_exp [$];
    logic             vec_zero [$];

    bit   loaded;        // Vectors are in, watchdog may start
    int   seed;
    int   pulse_cnt;     // result_valid_o pulses seen so far
    int   busy_starts;   // Rising edges of busy_o
    logic busy_prev;

    pm_top #(
        .WIDTH (WIDTH),
        .PRIME (PRIME)
    ) dut (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize_i      (zeroize_i),
        .cmd_i          (cmd_i),
        .operand_i      (operand_i),
        .scalar_i       (scalar_i),
        .busy_o         (busy_o),
        .result_o       (result_o),
        .result_valid_o (result_valid_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;  // 4 ns period
        end
    end

    // --------------------
    // Reporting
    // --------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_result(input logic [WIDTH-1:0] actual, input logic [WIDTH-1:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t ns: result_o expected %h got %h",
                                $time, expected, actual));
        end
    endtask

    task automatic check_busy(input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("** Error at %0t ns: busy_o expected %b got %b",
                                $time, expected, actual));
        end
    endtask

    // Falling edge, outputs settled; tally pulses and busy periods
    task automatic next_cycle();
        @(negedge clk);
        if (result_valid_o === 1'b1) begin
            pulse_cnt++;
        end
        if (busy_o === 1'b1 && busy_prev !== 1'b1) begin
            busy_starts++;
        end
        busy_prev = busy_o;
    endtask

    // --------------------
    // Data file
    // --------------------
    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_cmd;
        logic [31:0] f_x;
        logic [31:0] f_k;
        logic [31:0] f_exp;
        logic [31:0] f_zero;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            abort_run({"could not open ", TEST_FILE});
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            // Skip comments and blank lines
            if (code > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                code = $sscanf(line, "%h %h %h %h %h", f_cmd, f_x, f_k, f_exp, f_zero);
                if (code != 5 || f_cmd == 0 || f_cmd > 3) begin
                    abort_run({"malformed test line: ", line});
                end
                vec_cmd.push_back(pm_pkg::pm_cmd_e'(f_cmd[1:0]));
                vec_x.push_back(f_x[WIDTH-1:0]);
                vec_k.push_back(f_k[WIDTH-1:0]);
                vec_exp.push_back(f_exp[WIDTH-1:0]);
                vec_zero.push_back(f_zero[0]);
            end
        end
        $fclose(fd);
        if (vec_cmd.size() == 0) begin
            abort_run("test file holds no vectors");
        end
    endtask

    // --------------------
    // One command
    // --------------------
    task automatic run_vector(input int idx);
        int              wait_cnt;
        int              pulses_before;
        int              starts_before;
        int              delay;
        pm_pkg::pm_cmd_e other;
        pulses_before = pulse_cnt;
        starts_before = busy_starts;
        delay         = 8 + ($random(seed) & 31);  // Point of interference or abort
        other         = (vec_cmd[idx] == pm_pkg::CMD_SCALE) ? pm_pkg::CMD_POWER
                                                            : pm_pkg::CMD_SCALE;

        @(posedge clk);
        cmd_i     <= vec_cmd[idx];
        operand_i <= vec_x[idx];   // Held until the next vector
        scalar_i  <= vec_k[idx];
        next_cycle();
        @(posedge clk);            // DUT accepts on this edge
        cmd_i <= pm_pkg::CMD_NONE;
        next_cycle();
        check_busy(busy_o, 1'b1);

        repeat (delay) next_cycle();

        if (vec_zero[idx]) begin
            @(posedge clk);
            zeroize_i <= 1'b1;
            next_cycle();
            @(posedge clk);
            zeroize_i <= 1'b0;
            next_cycle();
            check_busy(busy_o, 1'b0);   // Idle right after the abort
            repeat (RUN_CYCLES) next_cycle();
            if (pulse_cnt != pulses_before) begin
                abort_run($sformatf("vector %0d: result_valid_o pulsed after zeroize", idx));
            end
            if (busy_starts != starts_before + 1) begin
                abort_run($sformatf("vector %0d: busy_o rose again after zeroize", idx));
            end
        end else begin
            // Other command while busy, must be ignored
            @(posedge clk);
            cmd_i <= other;
            repeat (3) begin
                next_cycle();
                check_busy(busy_o, 1'b1);
            end
            @(posedge clk);
            cmd_i <= pm_pkg::CMD_NONE;
            next_cycle();

            wait_cnt = 0;
            while (busy_o) begin
                next_cycle();
                wait_cnt++;
                if (wait_cnt > RUN_CYCLES) begin
                    abort_run($sformatf("vector %0d: busy_o never fell", idx));
                end
            end

            // Pulse due within 4 cycles of busy falling
            wait_cnt = 0;
            while (pulse_cnt == pulses_before && wait_cnt < 4) begin
                next_cycle();
                wait_cnt++;
            end
            if (pulse_cnt == pulses_before) begin
                abort_run($sformatf("vector %0d: no result_valid_o after busy fell", idx));
            end
            check_result(result_o, vec_exp[idx]);

            repeat (4) next_cycle();
            if (pulse_cnt != pulses_before + 1) begin
                abort_run($sformatf("vector %0d: %0d result pulses instead of one",
                                    idx, pulse_cnt - pulses_before));
            end
            if (busy_starts != starts_before + 1) begin
                abort_run($sformatf("vector %0d: extra busy period seen", idx));
            end
            check_busy(busy_o, 1'b0);
            check_result(result_o, vec_exp[idx]);   // Value holds after the pulse
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main_seq
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        cmd_i       = pm_pkg::CMD_NONE;
        operand_i   = '0;
        scalar_i    = '0;
        seed        = 55202;
        pulse_cnt   = 0;
        busy_starts = 0;
        busy_prev   = 1'b0;
        loaded      = 1'b0;

        load_vectors();
        loaded = 1'b1;

        repeat (4) @(posedge clk);   // Reset for 4 cycles
        reset_n <= 1'b1;
        next_cycle();
        check_busy(busy_o, 1'b0);
        check_result(result_o, '0);
        if (result_valid_o !== 1'b0) begin
            abort_run("result_valid_o is not low after reset");
        end

        for (int i = 0; i < vec_cmd.size(); i++) begin
            run_vector(i);
        end

        $display("No errors");
        $finish;
    end

    // Ends a hung run
    initial begin : watchdog
        wait (loaded);
        repeat (vec_cmd.size() * RUN_CYCLES + 100) @(posedge clk);
        abort_run("watchdog expired before all vectors finished");
    end

endmodule

`default_nettype wire

/* tests/pm_tests.txt */
// cmd (1 scale, 2 power, 3 invert), x, k, expected, zeroize; all hex, prime 0xfff1
// expected is k*x, x^k or x^(p-2) mod p; ignored on zeroize lines
1 1234 0003 369c 0
1 0005 0000 0000 0
1 0002 ffff 001c 0
1 0003 8000 800f 0
1 fff0 00ff fef2 0
2 0003 0000 0001 0
2 0002 000a 0400 0
2 0002 ffff 8000 0
2 0002 8000 0100 0
2 0100 0003 0f00 0
1 0007 00ff 0000 1
2 fff0 ffff fff0 0
3 0002 1234 7ff9 0
3 0000 ffff 0000 0
2 0002 0010 000f 1
3 0003 0000 aaa1 0
3 0100 5a5a eef2 0

/* pm_top.f */
logic/pm_pkg.sv
logic/pm_instr_if.sv
logic/pm_program_rom.sv
logic/pm_ctrl.sv
logic/pm_arith_unit.sv
logic/pm_top.sv
tests/pm_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pm_tb
FILELIST  ?= pm_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
